//--- src/board_pkg.sv
//################################################
// Board control package
// Status word fields, joystick bits, aspect ratios
// and the reset sequencer states
//################################################

package board_pkg;

    // OSD status word bit positions
    parameter int ST_ASPECT = 1;
    parameter int ST_ROT    = 2;
    // Effects level uses this bit and the next one
    parameter int ST_FX     = 3;
    parameter int ST_NOFM   = 5;
    parameter int ST_NOPSG  = 6;
    parameter int ST_TEST   = 10;
    parameter int ST_PAUSE  = 11;
    parameter int ST_FLIP   = 12;

    // Extra buttons on the board joystick
    parameter logic [3:0] JOY_SERVICE = 4'd10;
    parameter logic [3:0] JOY_PAUSE   = 4'd11;
    parameter logic [3:0] JOY_TEST    = 4'd12;

    parameter int JOY_W = 10;

    // Directions in 3:0, buttons above
    typedef logic [JOY_W-1:0] game_joy_t;
    typedef logic [15:0]      board_joy_t;

    // HDMI aspect ratios
    parameter logic [11:0] AR_WIDE_X = 12'd16;
    parameter logic [11:0] AR_WIDE_Y = 12'd9;
    parameter logic [11:0] AR_HORZ_X = 12'd4;
    parameter logic [11:0] AR_HORZ_Y = 12'd3;
    parameter logic [11:0] AR_VERT_X = 12'd3;
    parameter logic [11:0] AR_VERT_Y = 12'd4;

    typedef enum logic [1:0] {
        WAIT_LOCK,
        INIT,
        HOLD,
        RUN
    } rst_state_t;

endpackage

//--- src/board_ctrl_if.sv
//################################################
// Player control requests shared by input mapping,
// DIP decoding and the reset sequencer
//################################################

`timescale 1ns/1ps

interface board_ctrl_if;

    // One cycle pulse from the hold-to-reset combo
    logic soft_rst;
    // Toggled by the pause button
    logic pause_req;
    logic test_req;
    // Screen flip setting
    logic flip;

    modport inputs (
        output soft_rst,
        output pause_req,
        output test_req
    );

    modport dip (
        input  pause_req,
        input  test_req,
        output flip
    );

    modport rst (
        input  soft_rst,
        input  flip
    );

endinterface

//--- src/tick_timer.sv
//################################################
// Loadable down-counter with a sticky expiry flag
//################################################

`timescale 1ns/1ps

module tick_timer #(
    parameter int LEN = 16,
    parameter int CW  = $clog2(LEN + 1)
)(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic tick,
    output logic done
);

    logic [CW-1:0] cnt;
    logic          armed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            armed <= 1'b0;
            done  <= 1'b0;
        end else if (start) begin
            cnt   <= CW'(LEN);
            armed <= 1'b1;
            done  <= 1'b0;
        end else if (armed) begin
            // Expiry shows up one cycle after the count hits zero
            if (cnt == '0) begin
                done  <= 1'b1;
                armed <= 1'b0;
            end else if (tick) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

//--- src/reset_fsm.sv
//################################################
// Reset sequencer
// PLL lock, SDRAM init pulse, system reset release
// and game reset hold
//################################################

`timescale 1ns/1ps

module reset_fsm #(
    parameter int RST_HOLD = 16
)(
    input  logic      clk_sys,
    input  logic      rst_n,
    input  logic      pll_locked,
    input  logic      rst_req,
    input  logic      downloading,
    board_ctrl_if.rst ctrl,
    output logic      rst,
    output logic      game_rst_n,
    output logic      sdram_init
);

    board_pkg::rst_state_t state;
    board_pkg::rst_state_t state_nx;
    logic                  flip_l;
    logic                  flip_chg;
    logic                  init_start;
    logic                  init_done;

    assign flip_chg   = ctrl.flip != flip_l;
    assign init_start = (state == board_pkg::WAIT_LOCK) && pll_locked;

    // SDRAM init length, counted on every clock
    tick_timer #(
        .LEN   ( RST_HOLD    )
    ) u_init_timer (
        .clk   ( clk_sys     ),
        .rst_n ( rst_n       ),
        .start ( init_start  ),
        .tick  ( 1'b1        ),
        .done  ( init_done   )
    );

    always_comb begin
        state_nx = state;
        if (!pll_locked) begin
            state_nx = board_pkg::WAIT_LOCK;
        end else begin
            case (state)
                board_pkg::WAIT_LOCK: state_nx = board_pkg::INIT;
                board_pkg::INIT: begin
                    if (init_done)
                        state_nx = board_pkg::HOLD;
                end
                board_pkg::HOLD: begin
                    if (!downloading && !rst_req)
                        state_nx = board_pkg::RUN;
                end
                board_pkg::RUN: begin
                    // Any of these puts the game back in reset
                    if (rst_req || ctrl.soft_rst || downloading || flip_chg)
                        state_nx = board_pkg::HOLD;
                end
                default: state_nx = board_pkg::WAIT_LOCK;
            endcase
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state      <= board_pkg::WAIT_LOCK;
            flip_l     <= 1'b0;
            rst        <= 1'b1;
            game_rst_n <= 1'b0;
            sdram_init <= 1'b0;
        end else begin
            state      <= state_nx;
            flip_l     <= ctrl.flip;
            rst        <= (state_nx == board_pkg::WAIT_LOCK) || (state_nx == board_pkg::INIT);
            game_rst_n <= state_nx == board_pkg::RUN;
            sdram_init <= state_nx == board_pkg::INIT;
        end
    end

endmodule

//--- src/input_map.sv
//################################################
// Player input mapping
// Board joysticks, coin and start to game inputs,
// plus pause, test and the hold-to-reset combo
//################################################

`timescale 1ns/1ps

module input_map #(
    parameter int BUTTONS      = 2,
    parameter int ACTIVE_LOW   = 1,
    parameter int COMBO_FRAMES = 4
)(
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  LVBL,
    input  board_pkg::board_joy_t board_joystick1,
    input  board_pkg::board_joy_t board_joystick2,
    input  logic [1:0]            board_coin,
    input  logic [1:0]            board_start,
    board_ctrl_if.inputs          ctrl,
    output board_pkg::game_joy_t  game_joystick1,
    output board_pkg::game_joy_t  game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service
);

    localparam int JW = board_pkg::JOY_W;
    localparam logic INV = ACTIVE_LOW != 0;
    // Keep directions and the buttons the game uses
    localparam board_pkg::game_joy_t JOY_MASK =
        board_pkg::game_joy_t'((1 << (4 + BUTTONS)) - 1);

    logic pause_btn;
    logic pause_l;
    logic pause_q;
    logic test_q;
    logic soft_q;
    logic lvbl_l;
    logic frame;
    logic combo;
    logic combo_done;
    logic combo_done_l;

    assign pause_btn = board_joystick1[board_pkg::JOY_PAUSE] |
                       board_joystick2[board_pkg::JOY_PAUSE];
    // New frame on the start of vertical blank
    assign frame     = lvbl_l & ~LVBL;
    assign combo     = board_start[0] & board_coin[0];

    assign ctrl.soft_rst  = soft_q;
    assign ctrl.pause_req = pause_q;
    assign ctrl.test_req  = test_q;

    tick_timer #(
        .LEN   ( COMBO_FRAMES   )
    ) u_combo_timer (
        .clk   ( clk_sys        ),
        .rst_n ( rst_n          ),
        .start ( ~combo         ),
        .tick  ( frame          ),
        .done  ( combo_done     )
    );

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_joystick1 <= {JW{INV}};
            game_joystick2 <= {JW{INV}};
            game_coin      <= {2{INV}};
            game_start     <= {2{INV}};
            game_service   <= INV;
            pause_l        <= 1'b0;
            pause_q        <= 1'b0;
            test_q         <= 1'b0;
            soft_q         <= 1'b0;
            lvbl_l         <= 1'b0;
            combo_done_l   <= 1'b0;
        end else begin
            game_joystick1 <= (board_joystick1[JW-1:0] & JOY_MASK) ^ {JW{INV}};
            game_joystick2 <= (board_joystick2[JW-1:0] & JOY_MASK) ^ {JW{INV}};
            game_coin      <= board_coin ^ {2{INV}};
            game_start     <= board_start ^ {2{INV}};
            game_service   <= (board_joystick1[board_pkg::JOY_SERVICE] |
                               board_joystick2[board_pkg::JOY_SERVICE]) ^ INV;
            pause_l        <= pause_btn;
            if (pause_btn && !pause_l)
                pause_q <= ~pause_q;
            test_q         <= board_joystick1[board_pkg::JOY_TEST] |
                              board_joystick2[board_pkg::JOY_TEST];
            lvbl_l         <= LVBL;
            // Done stays up until the combo is released, so one pulse per hold
            combo_done_l   <= combo_done;
            soft_q         <= combo_done & ~combo_done_l;
        end
    end

endmodule

//--- src/dip_decode.sv
//################################################
// OSD status word decoder
// DIP style settings and the HDMI aspect ratio
//################################################

`timescale 1ns/1ps

module dip_decode (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [31:0] status,
    input  logic [6:0]  core_mod,
    board_ctrl_if.dip   ctrl,
    output logic [1:0]  rotate,
    output logic        dip_flip,
    output logic [1:0]  dip_fxlevel,
    output logic        enable_fm,
    output logic        enable_psg,
    output logic        dip_test,
    output logic        dip_pause,
    output logic [11:0] hdmi_arx,
    output logic [11:0] hdmi_ary
);

    logic flip_q;

    assign dip_flip  = flip_q;
    assign ctrl.flip = flip_q;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rotate      <= 2'b00;
            flip_q      <= 1'b0;
            dip_fxlevel <= 2'b00;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            hdmi_arx    <= 12'd0;
            hdmi_ary    <= 12'd0;
        end else begin
            // core_mod bit 0 flags a vertical game
            rotate      <= {status[board_pkg::ST_ROT], core_mod[0]};
            flip_q      <= status[board_pkg::ST_FLIP];
            dip_fxlevel <= status[board_pkg::ST_FX +: 2];
            enable_fm   <= ~status[board_pkg::ST_NOFM];
            enable_psg  <= ~status[board_pkg::ST_NOPSG];
            dip_test    <= status[board_pkg::ST_TEST] | ctrl.test_req;
            dip_pause   <= status[board_pkg::ST_PAUSE] | ctrl.pause_req;
            if (!status[board_pkg::ST_ASPECT]) begin
                hdmi_arx <= board_pkg::AR_WIDE_X;
                hdmi_ary <= board_pkg::AR_WIDE_Y;
            end else if (core_mod[0]) begin
                hdmi_arx <= board_pkg::AR_VERT_X;
                hdmi_ary <= board_pkg::AR_VERT_Y;
            end else begin
                hdmi_arx <= board_pkg::AR_HORZ_X;
                hdmi_ary <= board_pkg::AR_HORZ_Y;
            end
        end
    end

endmodule

//--- src/led_driver.sv
//################################################
// Board LED
// Blinks on ROM download, else shows game activity
//################################################

`timescale 1ns/1ps

module led_driver #(
    parameter int BLINK_FRAMES = 8
)(
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       LVBL,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int FW = $clog2(BLINK_FRAMES + 1);

    logic          lvbl_l;
    logic          frame;
    logic [FW-1:0] frame_cnt;
    logic          blink;

    assign frame = lvbl_l & ~LVBL;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            blink     <= 1'b0;
            led       <= 1'b0;
        end else begin
            lvbl_l <= LVBL;
            if (!downloading) begin
                frame_cnt <= '0;
            end else if (frame) begin
                if (frame_cnt == FW'(BLINK_FRAMES - 1)) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            // Download wins over the OSD
            if (downloading)
                led <= blink;
            else if (osd_shown)
                led <= 1'b0;
            else
                led <= game_led[0];
        end
    end

endmodule

//--- src/board_top.sv
//################################################
// Arcade board system control
// Reset sequencing, inputs, DIP settings and LED
//################################################

`timescale 1ns/1ps

module board_top #(
    parameter int BUTTONS      = 2,
    parameter int ACTIVE_LOW   = 1,
    parameter int RST_HOLD     = 16,
    parameter int COMBO_FRAMES = 4,
    parameter int BLINK_FRAMES = 8
)(
    input  logic                  clk_sys,
    input  logic                  rst_n,
    // Reset sequencing
    input  logic                  pll_locked,
    input  logic                  rst_req,
    input  logic                  downloading,
    output logic                  rst,
    output logic                  game_rst_n,
    output logic                  sdram_init,
    input  logic                  LVBL,
    // Player inputs
    input  board_pkg::board_joy_t board_joystick1,
    input  board_pkg::board_joy_t board_joystick2,
    input  logic [1:0]            board_coin,
    input  logic [1:0]            board_start,
    output board_pkg::game_joy_t  game_joystick1,
    output board_pkg::game_joy_t  game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service,
    // OSD settings
    input  logic [31:0]           status,
    input  logic [6:0]            core_mod,
    output logic [1:0]            rotate,
    output logic                  dip_flip,
    output logic [1:0]            dip_fxlevel,
    output logic                  enable_fm,
    output logic                  enable_psg,
    output logic                  dip_test,
    output logic                  dip_pause,
    output logic [11:0]           hdmi_arx,
    output logic [11:0]           hdmi_ary,
    // LED
    input  logic                  osd_shown,
    input  logic [1:0]            game_led,
    output logic                  led
);

    board_ctrl_if ctrl();

    reset_fsm #(
        .RST_HOLD    ( RST_HOLD     )
    ) u_reset (
        .clk_sys     ( clk_sys      ),
        .rst_n       ( rst_n        ),
        .pll_locked  ( pll_locked   ),
        .rst_req     ( rst_req      ),
        .downloading ( downloading  ),
        .ctrl        ( ctrl         ),
        .rst         ( rst          ),
        .game_rst_n  ( game_rst_n   ),
        .sdram_init  ( sdram_init   )
    );

    input_map #(
        .BUTTONS         ( BUTTONS          ),
        .ACTIVE_LOW      ( ACTIVE_LOW       ),
        .COMBO_FRAMES    ( COMBO_FRAMES     )
    ) u_inputs (
        .clk_sys         ( clk_sys          ),
        .rst_n           ( rst_n            ),
        .LVBL            ( LVBL             ),
        .board_joystick1 ( board_joystick1  ),
        .board_joystick2 ( board_joystick2  ),
        .board_coin      ( board_coin       ),
        .board_start     ( board_start      ),
        .ctrl            ( ctrl             ),
        .game_joystick1  ( game_joystick1   ),
        .game_joystick2  ( game_joystick2   ),
        .game_coin       ( game_coin        ),
        .game_start      ( game_start       ),
        .game_service    ( game_service     )
    );

    dip_decode u_dip (
        .clk_sys     ( clk_sys      ),
        .rst_n       ( rst_n        ),
        .status      ( status       ),
        .core_mod    ( core_mod     ),
        .ctrl        ( ctrl         ),
        .rotate      ( rotate       ),
        .dip_flip    ( dip_flip     ),
        .dip_fxlevel ( dip_fxlevel  ),
        .enable_fm   ( enable_fm    ),
        .enable_psg  ( enable_psg   ),
        .dip_test    ( dip_test     ),
        .dip_pause   ( dip_pause    ),
        .hdmi_arx    ( hdmi_arx     ),
        .hdmi_ary    ( hdmi_ary     )
    );

    led_driver #(
        .BLINK_FRAMES ( BLINK_FRAMES )
    ) u_led (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .LVBL         ( LVBL         ),
        .downloading  ( downloading  ),
        .osd_shown    ( osd_shown    ),
        .game_led     ( game_led     ),
        .led          ( led          )
    );

endmodule

//--- testbench/board_props.sv
//################################################
// Reset and pulse rules of the board control block
//################################################

`timescale 1ns/1ps

module board_props (
    input logic clk,
    input logic rst_n,
    input logic pll_locked,
    input logic rst,
    input logic game_rst_n,
    input logic sdram_init,
    input logic soft_rst
);

    // Read by the testbench at the end of the run
    int fail_cnt = 0;

    a_init_vs_game: assert property (@(posedge clk) disable iff (!rst_n)
        !(sdram_init && game_rst_n))
    else begin
        $error("sdram_init is high while the game runs");
        fail_cnt++;
    end

    a_soft_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        soft_rst |=> !soft_rst)
    else begin
        $error("soft_rst is high for two cycles in a row");
        fail_cnt++;
    end

    a_lock_rst: assert property (@(posedge clk) disable iff (!rst_n)
        !pll_locked |=> rst)
    else begin
        $error("rst is low after a cycle without PLL lock");
        fail_cnt++;
    end

endmodule

bind board_top board_props u_props (
    .clk        ( clk_sys       ),
    .rst_n      ( rst_n         ),
    .pll_locked ( pll_locked    ),
    .rst        ( rst           ),
    .game_rst_n ( game_rst_n    ),
    .sdram_init ( sdram_init    ),
    .soft_rst   ( ctrl.soft_rst )
);

//--- testbench/board_tb.sv
//################################################
// Testbench for the board control block
// Random stimulus against a cycle model
//################################################

`timescale 1ns/1ps

module board_tb;

    localparam int BUTTONS      = 2;
    localparam int ACTIVE_LOW   = 1;
    localparam int RST_HOLD     = 16;
    localparam int COMBO_FRAMES = 4;
    localparam int BLINK_FRAMES = 8;
    localparam int HALF_FRAME   = 20;
    localparam int SEL_SDRAM    = 0;
    localparam int SEL_GAME     = 1;

    logic                  clk_sys;
    logic                  rst_n;
    logic                  pll_locked;
    logic                  rst_req;
    logic                  downloading;
    logic                  LVBL;
    board_pkg::board_joy_t board_joystick1;
    board_pkg::board_joy_t board_joystick2;
    logic [1:0]            board_coin;
    logic [1:0]            board_start;
    logic [31:0]           status;
    logic [6:0]            core_mod;
    logic                  osd_shown;
    logic [1:0]            game_led;
    logic                  rst;
    logic                  game_rst_n;
    logic                  sdram_init;
    board_pkg::game_joy_t  game_joystick1;
    board_pkg::game_joy_t  game_joystick2;
    logic [1:0]            game_coin;
    logic [1:0]            game_start;
    logic                  game_service;
    logic [1:0]            rotate;
    logic                  dip_flip;
    logic [1:0]            dip_fxlevel;
    logic                  enable_fm;
    logic                  enable_psg;
    logic                  dip_test;
    logic                  dip_pause;
    logic [11:0]           hdmi_arx;
    logic [11:0]           hdmi_ary;
    logic                  led;

    int          value_errs;
    int          other_errs;
    int          cyc;
    logic [31:0] rng;
    // Model state of the pause toggle and the test button
    logic        m_pause;
    logic        m_btn_l;
    logic        m_test;

    board_top #(
        .BUTTONS      ( BUTTONS      ),
        .ACTIVE_LOW   ( ACTIVE_LOW   ),
        .RST_HOLD     ( RST_HOLD     ),
        .COMBO_FRAMES ( COMBO_FRAMES ),
        .BLINK_FRAMES ( BLINK_FRAMES )
    ) dut0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Keeps directions and used buttons and clears the rest
    function automatic board_pkg::game_joy_t map_joy(input board_pkg::board_joy_t b);
        board_pkg::game_joy_t j;
        for (int i = 0; i < board_pkg::JOY_W; i++)
            j[i] = (i < 4 + BUTTONS) ? b[i] : 1'b0;
        return (ACTIVE_LOW != 0) ? ~j : j;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SEL_SDRAM: return sdram_init;
            default:   return game_rst_n;
        endcase
    endfunction

    task automatic joy_compare(input string name, input board_pkg::game_joy_t got,
                               input board_pkg::game_joy_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic aspect_compare(input string name, input logic [11:0] got,
                                  input logic [11:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic pair_compare(input string name, input logic [1:0] got,
                                input logic [1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic bit_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // Predict, clock, compare, then update the model and LVBL
    task automatic advance();
        board_pkg::game_joy_t e_j1;
        board_pkg::game_joy_t e_j2;
        logic [1:0]           e_coin;
        logic [1:0]           e_start;
        logic [1:0]           e_rot;
        logic [11:0]          e_arx;
        logic [11:0]          e_ary;
        logic                 e_srv;
        logic                 e_test;
        logic                 e_pause;
        logic                 e_led;
        logic                 led_chk;
        logic                 btn;
        logic                 tbtn;
        e_j1    = map_joy(board_joystick1);
        e_j2    = map_joy(board_joystick2);
        e_coin  = (ACTIVE_LOW != 0) ? ~board_coin : board_coin;
        e_start = (ACTIVE_LOW != 0) ? ~board_start : board_start;
        e_srv   = board_joystick1[board_pkg::JOY_SERVICE] |
                  board_joystick2[board_pkg::JOY_SERVICE];
        e_srv   = (ACTIVE_LOW != 0) ? ~e_srv : e_srv;
        e_rot   = {status[board_pkg::ST_ROT], core_mod[0]};
        e_test  = status[board_pkg::ST_TEST] | m_test;
        e_pause = status[board_pkg::ST_PAUSE] | m_pause;
        if (!status[board_pkg::ST_ASPECT]) begin
            e_arx = 12'd16;
            e_ary = 12'd9;
        end else if (core_mod[0]) begin
            e_arx = 12'd3;
            e_ary = 12'd4;
        end else begin
            e_arx = 12'd4;
            e_ary = 12'd3;
        end
        led_chk = !downloading;
        e_led   = osd_shown ? 1'b0 : game_led[0];
        btn     = board_joystick1[board_pkg::JOY_PAUSE] | board_joystick2[board_pkg::JOY_PAUSE];
        tbtn    = board_joystick1[board_pkg::JOY_TEST] | board_joystick2[board_pkg::JOY_TEST];
        @(posedge clk_sys);
        #1;
        joy_compare("game_joystick1", game_joystick1, e_j1);
        joy_compare("game_joystick2", game_joystick2, e_j2);
        pair_compare("game_coin", game_coin, e_coin);
        pair_compare("game_start", game_start, e_start);
        bit_compare("game_service", game_service, e_srv);
        pair_compare("rotate", rotate, e_rot);
        bit_compare("dip_flip", dip_flip, status[board_pkg::ST_FLIP]);
        pair_compare("dip_fxlevel", dip_fxlevel, status[board_pkg::ST_FX +: 2]);
        bit_compare("enable_fm", enable_fm, ~status[board_pkg::ST_NOFM]);
        bit_compare("enable_psg", enable_psg, ~status[board_pkg::ST_NOPSG]);
        bit_compare("dip_test", dip_test, e_test);
        bit_compare("dip_pause", dip_pause, e_pause);
        aspect_compare("hdmi_arx", hdmi_arx, e_arx);
        aspect_compare("hdmi_ary", hdmi_ary, e_ary);
        if (led_chk)
            bit_compare("led", led, e_led);
        m_pause = m_pause ^ (btn & ~m_btn_l);
        m_btn_l = btn;
        m_test  = tbtn;
        cyc++;
        if (cyc % HALF_FRAME == 0)
            LVBL = ~LVBL;
    endtask

    task automatic wait_level(input int sel, input logic val, input int limit,
                              input string what);
        int n;
        n = 0;
        while (probe(sel) !== val && n < limit) begin
            advance();
            n++;
        end
        if (probe(sel) !== val) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            other_errs++;
        end
    endtask

    task automatic randomize_inputs();
        rng             = xorshift(rng);
        board_joystick1 = rng[15:0];
        board_joystick2 = rng[31:16];
        rng             = xorshift(rng);
        board_coin      = rng[1:0];
        board_start     = rng[3:2];
        core_mod        = rng[10:4];
        osd_shown       = rng[11];
        game_led        = rng[13:12];
        rng             = xorshift(rng);
        status          = rng;
    endtask

    initial begin
        int n;
        int falls;
        int changes;
        logic prev;
        value_errs      = 0;
        other_errs      = 0;
        cyc             = 0;
        rng             = 32'h8cdc_f8dc;
        m_pause         = 1'b0;
        m_btn_l         = 1'b0;
        m_test          = 1'b0;
        rst_n           = 1'b0;
        pll_locked      = 1'b0;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        LVBL            = 1'b1;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = 2'b00;
        board_start     = 2'b00;
        status          = 32'd0;
        core_mod        = 7'd0;
        osd_shown       = 1'b0;
        game_led        = 2'b00;
        repeat (5) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;

        // Reset sequence from PLL lock
        repeat (3) advance();
        bit_compare("rst", rst, 1'b1);
        bit_compare("game_rst_n", game_rst_n, 1'b0);
        bit_compare("sdram_init", sdram_init, 1'b0);
        pll_locked = 1'b1;
        wait_level(SEL_SDRAM, 1'b1, 4, "sdram_init to rise");
        n = 0;
        while (sdram_init === 1'b1 && n < 4 * RST_HOLD) begin
            advance();
            n++;
        end
        if (sdram_init === 1'b1) begin
            $display("Timed out waiting for sdram_init to fall");
            other_errs++;
        end else if (n < RST_HOLD + 1 || n > RST_HOLD + 3) begin
            $display("SDRAM init pulse lasted %0d cycles instead of %0d", n, RST_HOLD + 2);
            other_errs++;
        end
        bit_compare("rst", rst, 1'b0);
        wait_level(SEL_GAME, 1'b1, 3, "game_rst_n after init");

        // Game reset causes in RUN
        rst_req = 1'b1;
        wait_level(SEL_GAME, 1'b0, 2, "game reset on rst_req");
        rst_req = 1'b0;
        wait_level(SEL_GAME, 1'b1, 4, "recovery from rst_req");
        downloading = 1'b1;
        wait_level(SEL_GAME, 1'b0, 2, "game reset on download");
        downloading = 1'b0;
        wait_level(SEL_GAME, 1'b1, 4, "recovery from download");
        status[board_pkg::ST_FLIP] = 1'b1;
        wait_level(SEL_GAME, 1'b0, 2, "game reset on flip change");
        wait_level(SEL_GAME, 1'b1, 4, "recovery from flip change");

        // Random inputs and status words
        for (int i = 0; i < 200; i++) begin
            randomize_inputs();
            advance();
        end

        // Directed pause and test presses
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = 2'b00;
        board_start     = 2'b00;
        status          = 32'd0;
        osd_shown       = 1'b0;
        for (int i = 0; i < 4; i++) begin
            board_joystick1[board_pkg::JOY_PAUSE] = 1'b1;
            repeat (2) advance();
            board_joystick1[board_pkg::JOY_PAUSE] = 1'b0;
            repeat (2) advance();
        end
        board_joystick2[board_pkg::JOY_PAUSE] = 1'b1;
        status[board_pkg::ST_PAUSE]           = 1'b1;
        repeat (3) advance();
        board_joystick2[board_pkg::JOY_TEST] = 1'b1;
        repeat (3) advance();
        board_joystick2             = '0;
        status[board_pkg::ST_TEST]  = 1'b1;
        repeat (3) advance();
        status = 32'd0;
        repeat (3) advance();

        // Hold-to-reset combo gives one game reset
        wait_level(SEL_GAME, 1'b1, 10, "game running before combo");
        board_start = 2'b01;
        board_coin  = 2'b01;
        falls       = 0;
        for (int i = 0; i < (COMBO_FRAMES + 3) * 2 * HALF_FRAME; i++) begin
            prev = game_rst_n;
            advance();
            if (prev && !game_rst_n)
                falls++;
        end
        if (falls != 1) begin
            $display("Soft-reset combo gave %0d game resets instead of one", falls);
            other_errs++;
        end
        board_start = 2'b00;
        board_coin  = 2'b00;
        wait_level(SEL_GAME, 1'b1, 10, "game running after combo");

        // LED blinks during download
        downloading = 1'b1;
        advance();
        changes = 0;
        for (int i = 0; i < 3 * BLINK_FRAMES * 2 * HALF_FRAME; i++) begin
            prev = led;
            advance();
            if (prev !== led)
                changes++;
        end
        if (changes < 2 || changes > 3) begin
            $display("LED changed %0d times over %0d frames of download",
                     changes, 3 * BLINK_FRAMES);
            other_errs++;
        end
        downloading = 1'b0;
        game_led    = 2'b11;
        repeat (3) advance();
        osd_shown = 1'b1;
        repeat (3) advance();
        wait_level(SEL_GAME, 1'b1, 4, "game running after download");

        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errs, other_errs, dut0.u_props.fail_cnt);
        if (value_errs == 0 && other_errs == 0 && dut0.u_props.fail_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- filelist.f
src/board_pkg.sv
src/board_ctrl_if.sv
src/tick_timer.sv
src/reset_fsm.sv
src/input_map.sv
src/dip_decode.sv
src/led_driver.sv
src/board_top.sv
testbench/board_props.sv
testbench/board_tb.sv
